// ==== hdl/cacheGeomPkg.sv ====
`default_nettype none

package cacheGeomPkg;

  // request and data widths
  localparam int AddrBits    = 32;
  localparam int WordBits    = 64;

  // 32-byte lines of four 64-bit words
  localparam int OffsetBits  = 5;
  localparam int WordSelBits = 2;

  localparam int NumWays     = 2;

  typedef logic [AddrBits-1:0] addr_t;
  typedef logic [WordBits-1:0] word_t;

  // whole line address doubles as the stored tag
  typedef logic [AddrBits-OffsetBits-1:0] lineAddr_t;

  typedef word_t [2**WordSelBits-1:0] line_t;

endpackage

`default_nettype wire

// ==== hdl/cacheCtrlPkg.sv ====
`default_nettype none

package cacheCtrlPkg;

  typedef enum logic [2:0] {
    idle,
    lookup,
    respond,
    missReq,
    refill,
    replay
  } cacheState_e;

  // one line arrives as four beats, word 0 first
  localparam int BeatsPerLine = 4;
  localparam int BeatBits     = $clog2(BeatsPerLine);

  typedef logic [BeatBits-1:0] beatIdx_t;

endpackage

`default_nettype wire

// ==== hdl/refillIf.sv ====
`default_nettype none

interface refillIf;
  import cacheGeomPkg::*;
  import cacheCtrlPkg::*;

  logic      beatValid;
  beatIdx_t  beatIdx;
  word_t     beatData;

  // one-cycle pulse after the last beat of a line
  logic      install;
  lineAddr_t installLine;

  modport source (output beatValid, beatIdx, beatData, install, installLine);

  // tags only care about the install, data only about the beats
  modport tagSink (input install, installLine);
  modport dataSink (input beatValid, beatIdx, beatData, installLine);

endinterface

`default_nettype wire

// ==== hdl/cacheCtrl.sv ====
`default_nettype none

module cacheCtrl (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       reqValid_i,
  input  wire cacheGeomPkg::addr_t  reqAddr_i,
  input  wire                       respReady_i,
  input  wire                       hit_i,
  input  wire                       victimWay_i,
  input  wire                       refillDone_i,
  output logic                      reqReady_o,
  output logic                      respValid_o,
  output logic                      lookupEn_o,
  output cacheGeomPkg::addr_t       lookupAddr_o,
  output logic                      refillStart_o,
  output logic                      refillWay_o
);
  import cacheGeomPkg::*;
  import cacheCtrlPkg::*;

  cacheState_e state;
  cacheState_e stateNext;
  addr_t       reqLatch;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      idle: begin
        if (reqValid_i) begin
          stateNext = lookup;
        end
      end
      lookup: begin
        // hit answers in this same cycle
        if (!hit_i) begin
          stateNext = missReq;
        end else if (respReady_i) begin
          stateNext = idle;
        end else begin
          stateNext = respond;
        end
      end
      respond: begin
        if (respReady_i) begin
          stateNext = idle;
        end
      end
      missReq: stateNext = refill;
      refill: begin
        if (refillDone_i) begin
          stateNext = replay;
        end
      end
      replay:  stateNext = lookup;
      default: stateNext = idle;
    endcase
  end

  // single outstanding request
  always_ff @(posedge clk) begin
    if (reqReady_o && reqValid_i) begin
      reqLatch <= reqAddr_i;
    end
  end

  // victim frozen for the whole refill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      refillWay_o <= 1'b0;
    end else if (state == lookup && !hit_i) begin
      refillWay_o <= victimWay_i;
    end
  end

  assign reqReady_o    = (state == idle);
  assign respValid_o   = (state == lookup && hit_i) || (state == respond);
  assign lookupEn_o    = (reqReady_o && reqValid_i) || (state == replay);
  // arrays index with the live address on the accept edge
  assign lookupAddr_o  = reqReady_o ? reqAddr_i : reqLatch;
  assign refillStart_o = (state == missReq);

endmodule

`default_nettype wire

// ==== hdl/tagStore.sv ====
`default_nettype none

module tagStore #(
  parameter int NumSets = 64
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       lookupEn_i,
  input  wire cacheGeomPkg::addr_t  lookupAddr_i,
  refillIf.tagSink                  refill,
  input  wire                       refillWay_i,
  output logic                      hit_o,
  output logic                      hitWay_o,
  output logic                      victimWay_o
);
  import cacheGeomPkg::*;

  localparam int IndexBits = $clog2(NumSets);

  lineAddr_t            tagArr [NumWays][NumSets];
  logic [NumWays-1:0]   validArr [NumSets];
  // one bit per set, names the least recently used way
  logic [NumSets-1:0]   lruBits;

  lineAddr_t            tagRd [NumWays];
  logic [NumWays-1:0]   validRd;
  logic                 lruRd;
  logic                 cmpValid;
  logic [NumWays-1:0]   wayHit;

  lineAddr_t            lookupLine;
  logic [IndexBits-1:0] lookupIdx;
  logic [IndexBits-1:0] installIdx;

  assign lookupLine = lookupAddr_i[AddrBits-1:OffsetBits];
  assign lookupIdx  = lookupLine[IndexBits-1:0];
  assign installIdx = refill.installLine[IndexBits-1:0];

  always_ff @(posedge clk) begin
    if (refill.install) begin
      tagArr[refillWay_i][installIdx] <= refill.installLine;
    end
    if (lookupEn_i) begin
      for (int w = 0; w < NumWays; w++) begin
        tagRd[w] <= tagArr[w][lookupIdx];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '{default: '0};
      lruBits  <= '0;
    end else if (refill.install) begin
      validArr[installIdx][refillWay_i] <= 1'b1;
      lruBits[installIdx]               <= ~refillWay_i;
    end else if (cmpValid && hit_o) begin
      lruBits[lookupIdx] <= ~hitWay_o;
    end
  end

  // cmpValid marks the compare cycle after a read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validRd  <= '0;
      lruRd    <= 1'b0;
      cmpValid <= 1'b0;
    end else begin
      cmpValid <= lookupEn_i;
      if (lookupEn_i) begin
        validRd <= validArr[lookupIdx];
        lruRd   <= lruBits[lookupIdx];
      end
    end
  end

  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      wayHit[w] = validRd[w] && (tagRd[w] == lookupLine);
    end
  end

  assign hit_o       = |wayHit;
  assign hitWay_o    = wayHit[1];
  // empty way first, way 0 before way 1
  assign victimWay_o = !validRd[0] ? 1'b0 : (!validRd[1] ? 1'b1 : lruRd);

endmodule

`default_nettype wire

// ==== hdl/dataStore.sv ====
`default_nettype none

module dataStore #(
  parameter int NumSets = 64
) (
  input  wire                       clk,
  input  wire                       lookupEn_i,
  input  wire cacheGeomPkg::addr_t  lookupAddr_i,
  input  wire                       hitWay_i,
  refillIf.dataSink                 refill,
  input  wire                       refillWay_i,
  output cacheGeomPkg::word_t       hitWord_o
);
  import cacheGeomPkg::*;

  localparam int IndexBits = $clog2(NumSets);

  line_t                  lineArr [NumWays][NumSets];
  line_t                  lineRd [NumWays];

  logic [IndexBits-1:0]   lookupIdx;
  logic [IndexBits-1:0]   installIdx;
  logic [WordSelBits-1:0] wordSel;

  assign lookupIdx  = lookupAddr_i[OffsetBits +: IndexBits];
  assign installIdx = refill.installLine[IndexBits-1:0];
  // word within the line, byte offset bits 4:3
  assign wordSel    = lookupAddr_i[OffsetBits-1 -: WordSelBits];

  always_ff @(posedge clk) begin
    // beats land one word at a time in the victim way
    if (refill.beatValid) begin
      lineArr[refillWay_i][installIdx][refill.beatIdx] <= refill.beatData;
    end
    if (lookupEn_i) begin
      for (int w = 0; w < NumWays; w++) begin
        lineRd[w] <= lineArr[w][lookupIdx];
      end
    end
  end

  // read registers hold until the next lookup, so data stays put under stall
  assign hitWord_o = lineRd[hitWay_i][wordSel];

endmodule

`default_nettype wire

// ==== hdl/refillEngine.sv ====
`default_nettype none

module refillEngine (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          start_i,
  input  wire cacheGeomPkg::lineAddr_t lineAddr_i,
  output logic                         memReqValid_o,
  input  wire                          memReqReady_i,
  output cacheGeomPkg::addr_t          memReqAddr_o,
  input  wire                          memRespValid_i,
  input  wire cacheGeomPkg::word_t     memRespData_i,
  input  wire                          memRespLast_i,
  refillIf.source                      refill
);
  import cacheGeomPkg::*;
  import cacheCtrlPkg::*;

  lineAddr_t lineQ;
  beatIdx_t  beatCnt;
  logic      busy;
  logic      installQ;

  always_ff @(posedge clk) begin
    if (start_i) begin
      lineQ <= lineAddr_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      memReqValid_o <= 1'b0;
      busy          <= 1'b0;
      beatCnt       <= '0;
      installQ      <= 1'b0;
    end else begin
      installQ <= 1'b0;
      if (start_i) begin
        memReqValid_o <= 1'b1;
        beatCnt       <= '0;
      end else if (memReqValid_o && memReqReady_i) begin
        memReqValid_o <= 1'b0;
        busy          <= 1'b1;
      end
      // last flag ends the line, whatever the count says
      if (busy && memRespValid_i) begin
        beatCnt <= beatCnt + 1'b1;
        if (memRespLast_i) begin
          busy     <= 1'b0;
          installQ <= 1'b1;
        end
      end
    end
  end

  assign memReqAddr_o       = {lineQ, {OffsetBits{1'b0}}};

  assign refill.beatValid   = busy && memRespValid_i;
  assign refill.beatIdx     = beatCnt;
  assign refill.beatData    = memRespData_i;
  assign refill.install     = installQ;
  assign refill.installLine = lineQ;

endmodule

`default_nettype wire

// ==== hdl/cacheTop.sv ====
`default_nettype none

module cacheTop #(
  parameter int NumSets = 64
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       reqValid_i,
  output logic                      reqReady_o,
  input  wire cacheGeomPkg::addr_t  reqAddr_i,
  output logic                      respValid_o,
  output cacheGeomPkg::word_t       respData_o,
  input  wire                       respReady_i,
  output logic                      memReqValid_o,
  input  wire                       memReqReady_i,
  output cacheGeomPkg::addr_t       memReqAddr_o,
  input  wire                       memRespValid_i,
  input  wire cacheGeomPkg::word_t  memRespData_i,
  input  wire                       memRespLast_i
);
  import cacheGeomPkg::*;

  logic  lookupEn;
  addr_t lookupAddr;
  logic  hit;
  logic  hitWay;
  logic  victimWay;
  logic  refillStart;
  logic  refillWay;

  refillIf refillBus ();

  cacheCtrl i_cacheCtrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid_i),
    .reqAddr_i     (reqAddr_i),
    .respReady_i   (respReady_i),
    .hit_i         (hit),
    .victimWay_i   (victimWay),
    .refillDone_i  (refillBus.install),
    .reqReady_o    (reqReady_o),
    .respValid_o   (respValid_o),
    .lookupEn_o    (lookupEn),
    .lookupAddr_o  (lookupAddr),
    .refillStart_o (refillStart),
    .refillWay_o   (refillWay)
  );

  tagStore #(
    .NumSets (NumSets)
  ) i_tagStore (
    .clk          (clk),
    .rst_n        (rst_n),
    .lookupEn_i   (lookupEn),
    .lookupAddr_i (lookupAddr),
    .refill       (refillBus.tagSink),
    .refillWay_i  (refillWay),
    .hit_o        (hit),
    .hitWay_o     (hitWay),
    .victimWay_o  (victimWay)
  );

  dataStore #(
    .NumSets (NumSets)
  ) i_dataStore (
    .clk          (clk),
    .lookupEn_i   (lookupEn),
    .lookupAddr_i (lookupAddr),
    .hitWay_i     (hitWay),
    .refill       (refillBus.dataSink),
    .refillWay_i  (refillWay),
    .hitWord_o    (respData_o)
  );

  refillEngine i_refillEngine (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (refillStart),
    .lineAddr_i     (lookupAddr[AddrBits-1:OffsetBits]),
    .memReqValid_o  (memReqValid_o),
    .memReqReady_i  (memReqReady_i),
    .memReqAddr_o   (memReqAddr_o),
    .memRespValid_i (memRespValid_i),
    .memRespData_i  (memRespData_i),
    .memRespLast_i  (memRespLast_i),
    .refill         (refillBus.source)
  );

endmodule

`default_nettype wire

// ==== sim/cacheTb_chk.sv ====
`default_nettype none

module cacheTb_chk (
  input wire                         clk,
  input wire                         rst_n,
  input wire                         reqReady_i,
  input wire                         respValid_i,
  input wire                         respReady_i,
  input wire cacheGeomPkg::word_t    respData_i,
  input wire                         memReqValid_i,
  input wire                         memReqReady_i,
  input wire cacheGeomPkg::addr_t    memReqAddr_i,
  input wire                         beatValid_i,
  input wire cacheCtrlPkg::beatIdx_t beatIdx_i,
  input wire                         memRespLast_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import cacheCtrlPkg::*;

  // failure counts, read back by the testbench at the end of the run
  int unsigned respHoldFails = 0;
  int unsigned overlapFails  = 0;
  int unsigned memHoldFails  = 0;
  int unsigned lastFails     = 0;

  property respHeld;
    @(posedge clk) disable iff (!rst_n)
      respValid_i && !respReady_i |=> respValid_i && $stable(respData_i);
  endproperty

  property noAcceptDuringResp;
    @(posedge clk) disable iff (!rst_n)
      !(reqReady_i && respValid_i);
  endproperty

  property memReqHeld;
    @(posedge clk) disable iff (!rst_n)
      memReqValid_i && !memReqReady_i |=> memReqValid_i && $stable(memReqAddr_i);
  endproperty

  // last flag only on the final beat of a line
  property lastMatchesCount;
    @(posedge clk) disable iff (!rst_n)
      beatValid_i |-> (memRespLast_i == (beatIdx_i == beatIdx_t'(BeatsPerLine - 1)));
  endproperty

  aRespHeld: assert property (respHeld) else begin
    $error("response dropped or changed before it was accepted");
    respHoldFails++;
  end

  aNoOverlap: assert property (noAcceptDuringResp) else begin
    $error("request ready while a response is pending");
    overlapFails++;
  end

  aMemReqHeld: assert property (memReqHeld) else begin
    $error("memory request dropped or changed before ready");
    memHoldFails++;
  end

  aLastBeat: assert property (lastMatchesCount) else begin
    $error("memory last flag disagrees with the beat count");
    lastFails++;
  end

endmodule

// response data and the memory port only meet at the top level
bind cacheTop cacheTb_chk i_protoChk (
  .clk           (clk),
  .rst_n         (rst_n),
  .reqReady_i    (reqReady_o),
  .respValid_i   (respValid_o),
  .respReady_i   (respReady_i),
  .respData_i    (respData_o),
  .memReqValid_i (memReqValid_o),
  .memReqReady_i (memReqReady_i),
  .memReqAddr_i  (memReqAddr_o),
  .beatValid_i   (refillBus.beatValid),
  .beatIdx_i     (refillBus.beatIdx),
  .memRespLast_i (memRespLast_i)
);

`default_nettype wire

// ==== sim/cacheTb.sv ====
`default_nettype none

module cacheTb;
  timeunit 1ns;
  timeprecision 1ps;
  import cacheGeomPkg::*;
  import cacheCtrlPkg::*;

  localparam int          NumSets        = 64;
  localparam int          IdxBits        = $clog2(NumSets);
  localparam int          TagBits        = AddrBits - OffsetBits - IdxBits;
  localparam int          NumReqs        = 400;
  localparam int          WatchdogCycles = NumReqs * 40 + 200;
  localparam logic [31:0] Seed           = 32'd78551;

  logic  clk;
  logic  rst_n;
  logic  reqValid;
  logic  reqReady;
  addr_t reqAddr;
  logic  respValid;
  word_t respData;
  logic  respReady;
  logic  memReqValid;
  logic  memReqReady;
  addr_t memReqAddr;
  logic  memRespValid;
  word_t memRespData;
  logic  memRespLast;

  logic [31:0] reqRng = Seed;
  logic [31:0] memRng = Seed ^ 32'h2545_f491;
  int          memReqCount = 0;
  addr_t       lastMemAddr;
  int          errMismatch = 0;
  int          errOther    = 0;
  int          chkFails;

  // reference cache, one LRU bit per set naming the older way
  lineAddr_t modelTag [NumSets][NumWays];
  logic      modelValid [NumSets][NumWays];
  logic      modelLru [NumSets];

  int setList [4] = '{3, 17, 40, 63};

  cacheTop #(
    .NumSets (NumSets)
  ) i_cacheTop (
    .clk            (clk),
    .rst_n          (rst_n),
    .reqValid_i     (reqValid),
    .reqReady_o     (reqReady),
    .reqAddr_i      (reqAddr),
    .respValid_o    (respValid),
    .respData_o     (respData),
    .respReady_i    (respReady),
    .memReqValid_o  (memReqValid),
    .memReqReady_i  (memReqReady),
    .memReqAddr_o   (memReqAddr),
    .memRespValid_i (memRespValid),
    .memRespData_i  (memRespData),
    .memRespLast_i  (memRespLast)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // backing memory content, a fixed scramble of the byte address
  function automatic word_t memWord(input addr_t a);
    return {a ^ 32'hc3a5_5a3c, (a * 32'h9e37_79b1) ^ 32'h0f0f_1234};
  endfunction

  // updates the model and says whether the access should hit
  task automatic predictAccess(input addr_t addr, output logic isHit);
    lineAddr_t line;
    int        s;
    int        v;
    line  = addr[AddrBits-1:OffsetBits];
    s     = int'(line[IdxBits-1:0]);
    isHit = 1'b0;
    for (int w = 0; w < NumWays; w++) begin
      if (modelValid[s][w] && modelTag[s][w] == line) begin
        isHit       = 1'b1;
        modelLru[s] = (w == 0);
      end
    end
    if (!isHit) begin
      if (!modelValid[s][0]) v = 0;
      else if (!modelValid[s][1]) v = 1;
      else v = int'(modelLru[s]);
      modelTag[s][v]   = line;
      modelValid[s][v] = 1'b1;
      modelLru[s]      = (v == 0);
    end
  endtask

  task automatic runRequest(input addr_t addr);
    logic  isHit;
    logic  holdReady;
    logic  seen;
    logic  taken;
    int    memBefore;
    int    cycles;
    word_t held;
    word_t expData;
    predictAccess(addr, isHit);
    reqRng    = xorshift32(reqRng);
    holdReady = reqRng[0];
    memBefore = memReqCount;
    expData   = memWord(addr);
    reqValid  = 1'b1;
    reqAddr   = addr;
    while (!reqReady) @(negedge clk);
    // accepted on the coming rising edge
    @(negedge clk);
    reqValid = 1'b0;
    cycles   = 1;
    seen     = 1'b0;
    taken    = 1'b0;
    while (!taken) begin
      if (holdReady) begin
        respReady = 1'b1;
      end else begin
        reqRng    = xorshift32(reqRng);
        respReady = reqRng[1];
      end
      if (respValid) begin
        if (reqReady) begin
          errOther++;
          $display("ERROR: request ready while response for %h is pending", addr);
        end
        if (!seen) begin
          seen = 1'b1;
          held = respData;
          if (respData !== expData) begin
            errMismatch++;
            $display("MISMATCH respData_o addr=%h expected=%h actual=%h",
                     addr, expData, respData);
          end
          if (isHit && cycles != 1) begin
            errOther++;
            $display("ERROR: hit on %h answered after %0d cycles instead of 1", addr, cycles);
          end
        end else if (respData !== held) begin
          errMismatch++;
          $display("MISMATCH respData_o changed under stall expected=%h actual=%h",
                   held, respData);
        end
        taken = respReady;
      end else if (seen) begin
        errOther++;
        $display("ERROR: response for %h dropped before it was accepted", addr);
        taken = 1'b1;
      end
      @(negedge clk);
      cycles++;
    end
    if (isHit && memReqCount != memBefore) begin
      errOther++;
      $display("ERROR: expected hit on %h but a memory request was issued", addr);
    end
    if (!isHit) begin
      if (memReqCount != memBefore + 1) begin
        errOther++;
        $display("ERROR: expected one memory request for miss on %h, saw %0d",
                 addr, memReqCount - memBefore);
      end else if (lastMemAddr !== {addr[AddrBits-1:OffsetBits], {OffsetBits{1'b0}}}) begin
        errMismatch++;
        $display("MISMATCH memReqAddr_o expected=%h actual=%h",
                 {addr[AddrBits-1:OffsetBits], {OffsetBits{1'b0}}}, lastMemAddr);
      end
    end
  endtask

  // backing memory with random accept and beat gaps
  always begin : memResponder
    addr_t lineBase;
    @(negedge clk);
    if (memReqValid) begin
      memRng = xorshift32(memRng);
      repeat (memRng % 6) @(negedge clk);
      memReqReady = 1'b1;
      lineBase    = memReqAddr;
      lastMemAddr = memReqAddr;
      memReqCount++;
      @(negedge clk);
      memReqReady = 1'b0;
      for (int b = 0; b < BeatsPerLine; b++) begin
        memRng = xorshift32(memRng);
        repeat (memRng % 6) @(negedge clk);
        memRespValid = 1'b1;
        memRespData  = memWord(lineBase + b * 8);
        memRespLast  = (b == BeatsPerLine - 1);
        @(negedge clk);
        memRespValid = 1'b0;
        memRespLast  = 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clk);
    $display("ERROR: timeout, run did not finish within %0d cycles", WatchdogCycles);
    $display("TB FAILED");
    $finish;
  end

  initial begin : stimulus
    int tagSel;
    int setSel;
    clk          = 1'b0;
    rst_n        = 1'b0;
    reqValid     = 1'b0;
    reqAddr      = '0;
    respReady    = 1'b0;
    memReqReady  = 1'b0;
    memRespValid = 1'b0;
    memRespData  = '0;
    memRespLast  = 1'b0;
    tagSel       = 0;
    setSel       = 0;
    for (int s = 0; s < NumSets; s++) begin
      modelLru[s] = 1'b0;
      for (int w = 0; w < NumWays; w++) begin
        modelValid[s][w] = 1'b0;
        modelTag[s][w]   = '0;
      end
    end
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (!reqReady || respValid || memReqValid) begin
      errOther++;
      $display("ERROR: outputs not in their idle state after reset");
    end
    for (int n = 0; n < NumReqs; n++) begin
      reqRng = xorshift32(reqRng);
      // half the time stay on the previous line so hits occur
      if (n == 0 || reqRng[4]) begin
        tagSel = int'(reqRng[15:8]) % 12;
        setSel = int'(reqRng[17:16]);
      end
      runRequest({TagBits'(21'h00a5 + tagSel * 21'h0113), IdxBits'(setList[setSel]),
                  WordSelBits'(reqRng[21:20]), 3'b000});
    end
    chkFails = int'(i_cacheTop.i_protoChk.respHoldFails + i_cacheTop.i_protoChk.overlapFails +
                    i_cacheTop.i_protoChk.memHoldFails + i_cacheTop.i_protoChk.lastFails);
    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             errMismatch, errOther, chkFails);
    if (errMismatch + errOther + chkFails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== cacheTop.f ====
hdl/cacheGeomPkg.sv
hdl/cacheCtrlPkg.sv
hdl/refillIf.sv
hdl/cacheCtrl.sv
hdl/tagStore.sv
hdl/dataStore.sv
hdl/refillEngine.sv
hdl/cacheTop.sv
sim/cacheTb_chk.sv
sim/cacheTb.sv

// ==== Makefile ====
# Verilator build and run for the set-associative read cache

VERILATOR ?= verilator
TOP       ?= cacheTb
FILELIST  ?= cacheTop.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) $(RUN_ARGS) | tee $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
